/* buf_wr_if.sv */
`timescale 1ns/10ps

interface buf_wr_if import mcntrl_pkg::*; #(
    parameter int LOG2_PAGE_WORDS = 4  // log2 of 64-bit words per page
) ();
    logic [PAGE_BITS+LOG2_PAGE_WORDS:0] waddr;     // page, 32-bit word
    logic                               we;        // host word write
    logic [WB_DAT_BITS-1:0]             wdata;
    logic [PAGE_BITS-1:0]               rpage_in;  // new read page
    logic                               rpage_set; // load rpage_in
    logic                               page_next; // advance read page
    logic                               rd;        // read one 64-bit word
    logic [PAGE_BITS-1:0]               page;      // current read page
    logic [MEM_DAT_BITS-1:0]            data_out;  // 2 cycles after rd

    modport host (
        output waddr, we, wdata, rpage_in, rpage_set,
        input  page
    );

    modport drain (
        output page_next, rd,
        input  data_out
    );

    modport buffer (
        input  waddr, we, wdata, rpage_in, rpage_set, page_next, rd,
        output page, data_out
    );

endinterface

/* build.f */
mcntrl_pkg.sv
buf_wr_if.sv
ram_var_w_var_r.sv
mcntrl_buf_wr.sv
wb_buf_slave.sv
wr_chan_drain.sv
mcntrl_wbuf_top.sv
tb_mcntrl_wbuf.sv

/* mcntrl_buf_wr.sv */
`timescale 1ns/10ps

module mcntrl_buf_wr import mcntrl_pkg::*; #(
    parameter int LOG2_PAGE_WORDS = 4  // 16 memory words per page
) (
    input  logic     rclk,
    input  logic     arst_n,
    buf_wr_if.buffer bus
);
    logic [PAGE_BITS-1:0]       page_r;  // read page
    logic [LOG2_PAGE_WORDS-1:0] raddr;   // word within read page
    logic                       regen;   // rd one cycle late

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            page_r <= '0;
            raddr  <= '0;
            regen  <= 1'b0;
        end else begin
            regen <= bus.rd;  // output register follows array read

            if (bus.rpage_set) begin
                page_r <= bus.rpage_in;
            end else if (bus.page_next) begin
                page_r <= page_r + 1'b1;  // wraps 3 -> 0
            end

            if (bus.rpage_set || bus.page_next) begin
                raddr <= '0;  // new page starts at word 0
            end else if (bus.rd) begin
                raddr <= raddr + 1'b1;  // autoincrement
            end
        end
    end

    assign bus.page = page_r;

    ram_var_w_var_r #(
        .REGISTERS  (1),
        .RADDR_BITS (PAGE_BITS + LOG2_PAGE_WORDS)
    ) i_ram (
        .rclk     (rclk),
        .waddr    (bus.waddr),       // host side, page and word
        .we       (bus.we),
        .data_in  (bus.wdata),
        .raddr    ({page_r, raddr}),
        .ren      (bus.rd),
        .regen    (regen),
        .data_out (bus.data_out)     // valid 2 cycles after rd
    );

endmodule

/* mcntrl_pkg.sv */
package mcntrl_pkg;

    localparam int NUM_CHAN_MAX  = 4;                     // channel field sized for this
    localparam int CHAN_BITS     = $clog2(NUM_CHAN_MAX);  // 2 bits of channel select
    localparam int PAGE_BITS     = 2;                     // four pages per channel
    localparam int WORD_BITS_MAX = 5;                     // up to 32 host words per page
    localparam int WB_ADR_BITS   = 10;                    // wishbone word address
    localparam int WB_DAT_BITS   = 32;                    // host data width
    localparam int MEM_DAT_BITS  = 64;                    // memory side data width

    // control register codes, low two address bits of control space
    typedef enum logic [1:0] {
        REG_COMMIT   = 2'd0,  // mark read page full, set pending
        REG_PAGE_SET = 2'd1,  // load read page from wb_dat_i[1:0]
        REG_STATUS   = 2'd2   // {page, pending} readback
    } reg_code_e;

    typedef struct packed {
        logic                     ctrl;  // 0 here, buffer space
        logic [CHAN_BITS-1:0]     chan;
        logic [PAGE_BITS-1:0]     page;
        logic [WORD_BITS_MAX-1:0] word;  // 32-bit word index in page
    } buf_addr_t;

    typedef struct packed {
        logic                               ctrl;  // 1 here, control space
        logic [CHAN_BITS-1:0]               chan;
        logic [WB_ADR_BITS-CHAN_BITS-4:0]   rsvd;  // ignored by the slave
        reg_code_e                          code;
    } ctrl_addr_t;

    // one wishbone word address, two ways to read it
    typedef union packed {
        buf_addr_t  buf_a;
        ctrl_addr_t ctrl_a;
    } wb_adr_u;

endpackage

/* mcntrl_wbuf_top.sv */
`timescale 1ns/10ps

module mcntrl_wbuf_top import mcntrl_pkg::*; #(
    parameter int NUM_CHAN        = 4,  // at most NUM_CHAN_MAX
    parameter int LOG2_PAGE_WORDS = 4   // at most WORD_BITS_MAX-1
) (
    input  logic                    rclk,
    input  logic                    arst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [WB_ADR_BITS-1:0]  wb_adr,
    input  logic [WB_DAT_BITS-1:0]  wb_dat_i,
    output logic [WB_DAT_BITS-1:0]  wb_dat_o,
    output logic                    wb_ack,
    output logic                    mem_valid,
    input  logic                    mem_ready,
    output logic [MEM_DAT_BITS-1:0] mem_data,
    output logic [CHAN_BITS-1:0]    mem_chan,
    output logic                    mem_last
);
    logic [NUM_CHAN-1:0] commit;   // slave to drain
    logic [NUM_CHAN-1:0] pending;  // drain to slave status

    buf_wr_if #(.LOG2_PAGE_WORDS(LOG2_PAGE_WORDS)) chan_if [NUM_CHAN] ();

    wb_buf_slave #(
        .NUM_CHAN        (NUM_CHAN),
        .LOG2_PAGE_WORDS (LOG2_PAGE_WORDS)
    ) i_slave (
        .rclk     (rclk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),    // decoded as wb_adr_u inside
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .bus      (chan_if),
        .commit   (commit),
        .pending  (pending)
    );

    genvar i;
    generate
        for (i = 0; i < NUM_CHAN; i++) begin : g_buf
            mcntrl_buf_wr #(
                .LOG2_PAGE_WORDS (LOG2_PAGE_WORDS)
            ) i_buf (
                .rclk   (rclk),
                .arst_n (arst_n),
                .bus    (chan_if[i])
            );
        end
    endgenerate

    wr_chan_drain #(
        .NUM_CHAN        (NUM_CHAN),
        .LOG2_PAGE_WORDS (LOG2_PAGE_WORDS)
    ) i_drain (
        .rclk      (rclk),
        .arst_n    (arst_n),
        .bus       (chan_if),
        .commit    (commit),
        .pending   (pending),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_data  (mem_data),
        .mem_chan  (mem_chan),
        .mem_last  (mem_last)
    );

endmodule

/* ram_var_w_var_r.sv */
`timescale 1ns/10ps

module ram_var_w_var_r import mcntrl_pkg::*; #(
    parameter int REGISTERS  = 1,  // 1 adds output register loaded on regen
    parameter int RADDR_BITS = 6   // 64-bit word address width
) (
    input  logic                    rclk,
    input  logic [RADDR_BITS:0]     waddr,     // 32-bit word address
    input  logic                    we,
    input  logic [WB_DAT_BITS-1:0]  data_in,
    input  logic [RADDR_BITS-1:0]   raddr,
    input  logic                    ren,
    input  logic                    regen,
    output logic [MEM_DAT_BITS-1:0] data_out
);
    localparam int DEPTH = 1 << RADDR_BITS;

    // even host words land in the low half, odd in the high half
    logic [WB_DAT_BITS-1:0]  mem_lo [DEPTH];
    logic [WB_DAT_BITS-1:0]  mem_hi [DEPTH];
    logic [MEM_DAT_BITS-1:0] ram_q;  // array read latch

    always_ff @(posedge rclk) begin
        if (we && !waddr[0]) begin
            mem_lo[waddr[RADDR_BITS:1]] <= data_in;  // earlier word of the pair
        end
        if (we && waddr[0]) begin
            mem_hi[waddr[RADDR_BITS:1]] <= data_in;
        end
    end

    always_ff @(posedge rclk) begin
        if (ren) begin
            ram_q <= {mem_hi[raddr], mem_lo[raddr]};  // one 64-bit word
        end
    end

    generate
        if (REGISTERS != 0) begin : g_oreg
            logic [MEM_DAT_BITS-1:0] out_r;  // second read stage

            always_ff @(posedge rclk) begin
                if (regen) begin
                    out_r <= ram_q;
                end
            end

            assign data_out = out_r;
        end else begin : g_noreg
            assign data_out = ram_q;  // latency 1 here
        end
    endgenerate

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the write buffer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_mcntrl_wbuf -o tb_sim

# the log decides the result, so a nonzero simulator exit must not stop the script here
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation ok"
    exit 0
fi
echo "simulation did not pass"
exit 1

/* tb_mcntrl_wbuf.sv */
`timescale 1ns/10ps

module tb_mcntrl_wbuf import mcntrl_pkg::*; ();
    localparam int NUM_CHAN        = 4;                     // dut default
    localparam int LOG2_PAGE_WORDS = 4;                     // dut default
    localparam int PAGE_WORDS      = 1 << LOG2_PAGE_WORDS;  // 64-bit words per page
    localparam int HOST_WORDS      = 2 * PAGE_WORDS;        // 32-bit writes per page
    localparam int WAIT_LIMIT      = 200;                   // idle cycles before giving up

    logic                    rclk;
    logic                    arst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [WB_ADR_BITS-1:0]  wb_adr;
    logic [WB_DAT_BITS-1:0]  wb_dat_i;
    logic [WB_DAT_BITS-1:0]  wb_dat_o;
    logic                    wb_ack;
    logic                    mem_valid;
    logic                    mem_ready;
    logic [MEM_DAT_BITS-1:0] mem_data;
    logic [CHAN_BITS-1:0]    mem_chan;
    logic                    mem_last;

    logic [31:0]             lcg_state;                            // random source
    logic [WB_DAT_BITS-1:0]  host_mem [NUM_CHAN][4][HOST_WORDS];   // host words written
    logic [PAGE_BITS-1:0]    exp_page [NUM_CHAN];                  // read page per channel
    int                      exp_order [$];                        // expected burst channels
    logic [MEM_DAT_BITS-1:0] got_data [$];                         // collected at memory port
    logic [CHAN_BITS-1:0]    got_chan [$];
    logic                    got_last [$];

    mcntrl_wbuf_top i_dut (
        .rclk      (rclk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_data  (mem_data),
        .mem_chan  (mem_chan),
        .mem_last  (mem_last)
    );

    always #5 rclk = ~rclk;  // 10 ns period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [WB_ADR_BITS-1:0] buf_adr(input int chan, input int page,
                                                       input int word);
        wb_adr_u a;
        a = '0;
        a.buf_a.chan = CHAN_BITS'(chan);  // ctrl flag stays 0
        a.buf_a.page = PAGE_BITS'(page);
        a.buf_a.word = WORD_BITS_MAX'(word);
        return a;
    endfunction

    function automatic logic [WB_ADR_BITS-1:0] ctrl_adr(input int chan, input reg_code_e code);
        wb_adr_u a;
        a = '0;
        a.ctrl_a.ctrl = 1'b1;  // control space
        a.ctrl_a.chan = CHAN_BITS'(chan);
        a.ctrl_a.code = code;
        return a;
    endfunction

    // first waiting channel after the one last served
    function automatic int next_rr(input int last, input logic [NUM_CHAN-1:0] mask);
        int c;
        for (int k = 1; k <= NUM_CHAN; k++) begin
            c = (last + k) % NUM_CHAN;
            if (mask[c]) return c;
        end
        return -1;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic wb_access(input logic we, input logic [WB_ADR_BITS-1:0] adr,
                             input logic [WB_DAT_BITS-1:0] dat,
                             output logic [WB_DAT_BITS-1:0] rdat);
        int n;
        @(posedge rclk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = dat;
        n = 0;
        while (!wb_ack) begin
            @(posedge rclk);
            #1;
            n++;
            if (n > 8) fail_timeout("wishbone ack");
        end
        check_eq(64'(n), 64'd1, "ack one cycle after start");
        rdat = wb_dat_o;  // status valid in ack cycle
        @(posedge rclk);  // control writes land on this edge
        #1;
        check_eq(64'(wb_ack), 64'd0, "ack longer than one cycle");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_BITS-1:0] adr, input logic [WB_DAT_BITS-1:0] dat);
        logic [WB_DAT_BITS-1:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADR_BITS-1:0] adr, output logic [WB_DAT_BITS-1:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic check_status(input int chan, input logic pend);
        logic [WB_DAT_BITS-1:0] st;
        wb_read(ctrl_adr(chan, REG_STATUS), st);
        check_eq(64'(st), 64'({29'd0, exp_page[chan], pend}), "status register");
    endtask

    // fills the channel's current read page with random host words
    task automatic fill_page(input int chan);
        logic [31:0] d;
        int p;
        p = int'(exp_page[chan]);
        for (int w = 0; w < HOST_WORDS; w++) begin
            d = lcg_next();
            host_mem[chan][p][w] = d;
            wb_write(buf_adr(chan, p, w), d);
        end
    endtask

    task automatic collect_words(input int n, input bit use_rand);
        int idle;
        logic [31:0] rnd;
        logic r;
        idle = 0;
        while (got_data.size() < n) begin
            @(posedge rclk);
            #1;
            rnd = lcg_next();
            r = use_rand ? rnd[16] : 1'b1;
            mem_ready = r;
            if (r && mem_valid) begin  // transfer on the coming edge
                got_data.push_back(mem_data);
                got_chan.push_back(mem_chan);
                got_last.push_back(mem_last);
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) fail_timeout("memory port word");
            end
        end
        @(posedge rclk);  // let the last word go
        #1;
        mem_ready = 1'b0;
    endtask

    // whole bursts in exp_order, pairs packed low word first, then pages advance
    task automatic check_bursts();
        int c;
        int p;
        int k;
        logic [63:0] exp_word;
        for (int b = 0; b < exp_order.size(); b++) begin
            c = exp_order[b];
            p = int'(exp_page[c]);
            for (int j = 0; j < PAGE_WORDS; j++) begin
                k = b * PAGE_WORDS + j;
                exp_word = {host_mem[c][p][2*j+1], host_mem[c][p][2*j]};
                check_eq(64'(got_chan[k]), 64'(c), "mem_chan");
                check_eq(got_data[k], exp_word, "mem_data");
                check_eq(64'(got_last[k]), 64'(j == PAGE_WORDS - 1), "mem_last");
            end
            exp_page[c] = exp_page[c] + 1'b1;
        end
        for (int i = 0; i < 20; i++) begin  // nothing extra
            @(posedge rclk);
            #1;
            check_eq(64'(mem_valid), 64'd0, "mem_valid after bursts");
        end
        got_data.delete();
        got_chan.delete();
        got_last.delete();
        exp_order.delete();
    endtask

    task automatic test_reset_state();
        for (int ch = 0; ch < NUM_CHAN; ch++) check_status(ch, 1'b0);
        for (int i = 0; i < 20; i++) begin
            @(posedge rclk);
            #1;
            check_eq(64'(mem_valid), 64'd0, "mem_valid after reset");
        end
    endtask

    task automatic test_single_page();
        fill_page(0);
        wb_write(ctrl_adr(0, REG_COMMIT), '0);
        exp_order.push_back(0);
        collect_words(PAGE_WORDS, 1'b0);
        check_bursts();
        check_status(0, 1'b0);  // page 1 now
    endtask

    task automatic test_page_set_wrap();
        wb_write(ctrl_adr(2, REG_PAGE_SET), 32'd3);
        exp_page[2] = 2'd3;
        check_status(2, 1'b0);
        fill_page(2);
        wb_write(ctrl_adr(2, REG_COMMIT), '0);
        exp_order.push_back(2);
        collect_words(PAGE_WORDS, 1'b0);
        check_bursts();
        check_status(2, 1'b0);  // wrapped to page 0
    endtask

    // channel 2 stalls the drain with ready low while 1, 3 and 0 commit
    task automatic test_round_robin(input bit use_rand);
        logic [NUM_CHAN-1:0] waiting;
        int last;
        for (int ch = 0; ch < NUM_CHAN; ch++) fill_page(ch);
        mem_ready = 1'b0;
        wb_write(ctrl_adr(2, REG_COMMIT), '0);
        wb_write(ctrl_adr(1, REG_COMMIT), '0);
        wb_write(ctrl_adr(3, REG_COMMIT), '0);
        wb_write(ctrl_adr(0, REG_COMMIT), '0);
        for (int ch = 0; ch < NUM_CHAN; ch++) check_status(ch, 1'b1);
        waiting = 4'b1011;
        last = 2;
        exp_order.push_back(last);
        while (waiting != '0) begin
            last = next_rr(last, waiting);
            exp_order.push_back(last);
            waiting[last] = 1'b0;
        end
        collect_words(NUM_CHAN * PAGE_WORDS, use_rand);
        check_bursts();
        for (int ch = 0; ch < NUM_CHAN; ch++) check_status(ch, 1'b0);
    endtask

    initial begin
        rclk      = 1'b0;
        arst_n    = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        mem_ready = 1'b0;
        lcg_state = 32'd60;
        for (int ch = 0; ch < NUM_CHAN; ch++) exp_page[ch] = '0;
        repeat (16) @(posedge rclk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_single_page();
        test_page_set_wrap();
        test_round_robin(1'b0);
        test_round_robin(1'b1);  // random back-pressure

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* wb_buf_slave.sv */
`timescale 1ns/10ps

module wb_buf_slave import mcntrl_pkg::*; #(
    parameter int NUM_CHAN        = 4,
    parameter int LOG2_PAGE_WORDS = 4  // slices the word index
) (
    input  logic                   rclk,
    input  logic                   arst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  wb_adr_u                wb_adr,
    input  logic [WB_DAT_BITS-1:0] wb_dat_i,
    output logic [WB_DAT_BITS-1:0] wb_dat_o,
    output logic                   wb_ack,
    buf_wr_if.host                 bus [NUM_CHAN],
    output logic [NUM_CHAN-1:0]    commit,    // one pulse per commit write
    input  logic [NUM_CHAN-1:0]    pending    // from drain, for status
);
    logic                   start;     // first cycle of an access
    logic                   buf_wr;    // buffer space write, first cycle
    logic                   ctrl_wr;   // control write, ack cycle
    logic [WB_DAT_BITS-1:0] stat [NUM_CHAN];

    assign start   = wb_cyc && wb_stb && !wb_ack;
    assign buf_wr  = start && wb_we && !wb_adr.buf_a.ctrl;
    assign ctrl_wr = wb_ack && wb_we && wb_adr.ctrl_a.ctrl;  // address held through ack

    // ack one cycle after start, high for a single cycle
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= start;
        end
    end

    genvar i;
    generate
        for (i = 0; i < NUM_CHAN; i++) begin : g_chan
            logic sel;  // address names this channel

            assign sel = (wb_adr.buf_a.chan == CHAN_BITS'(i));

            assign bus[i].waddr = {wb_adr.buf_a.page, wb_adr.buf_a.word[LOG2_PAGE_WORDS:0]};
            assign bus[i].wdata = wb_dat_i;
            assign bus[i].we    = buf_wr && sel;  // stored at once

            assign bus[i].rpage_in  = wb_dat_i[PAGE_BITS-1:0];
            assign bus[i].rpage_set = ctrl_wr && sel &&
                                      (wb_adr.ctrl_a.code == REG_PAGE_SET);
            assign commit[i]        = ctrl_wr && sel &&
                                      (wb_adr.ctrl_a.code == REG_COMMIT);

            // bit 0 pending, bits 2:1 read page
            assign stat[i] = {{(WB_DAT_BITS-PAGE_BITS-1){1'b0}}, bus[i].page, pending[i]};
        end
    endgenerate

    // buffer space and unknown codes read as zero
    always_comb begin
        wb_dat_o = '0;
        if (wb_adr.ctrl_a.ctrl && (wb_adr.ctrl_a.code == REG_STATUS) &&
            (int'(wb_adr.ctrl_a.chan) < NUM_CHAN)) begin
            wb_dat_o = stat[wb_adr.ctrl_a.chan];
        end
    end

endmodule

/* wr_chan_drain.sv */
`timescale 1ns/10ps

module wr_chan_drain import mcntrl_pkg::*; #(
    parameter int NUM_CHAN        = 4,
    parameter int LOG2_PAGE_WORDS = 4
) (
    input  logic                    rclk,
    input  logic                    arst_n,
    buf_wr_if.drain                 bus [NUM_CHAN],
    input  logic [NUM_CHAN-1:0]     commit,
    output logic [NUM_CHAN-1:0]     pending,
    output logic                    mem_valid,
    input  logic                    mem_ready,
    output logic [MEM_DAT_BITS-1:0] mem_data,
    output logic [CHAN_BITS-1:0]    mem_chan,
    output logic                    mem_last
);
    logic                       busy;      // burst in progress
    logic                       pn_r;      // page_next pulse after last rd
    logic [CHAN_BITS-1:0]       cur_chan;  // channel served, or last served
    logic [LOG2_PAGE_WORDS-1:0] rd_cnt;    // reads issued in this burst
    logic                       gnt_vld;
    logic [CHAN_BITS-1:0]       gnt_chan;
    logic                       issue;     // rd this cycle
    logic                       last_rd;
    logic [3:0]                 credit;    // fifo entries plus words in flight
    logic                       v1, v2;    // read issued 1 and 2 cycles ago
    logic [CHAN_BITS-1:0]       c1, c2;
    logic                       l1, l2;
    logic [MEM_DAT_BITS-1:0]    rdata [NUM_CHAN];

    logic [MEM_DAT_BITS-1:0]    fifo_data [4];  // skid toward memory port
    logic [CHAN_BITS-1:0]       fifo_chan [4];
    logic                       fifo_last [4];
    logic [1:0]                 wr_ptr, rd_ptr;
    logic [2:0]                 fifo_cnt;
    logic                       push, pop;

    // round-robin, nearest pending channel after cur_chan wins
    always_comb begin
        int idx;
        gnt_vld  = 1'b0;
        gnt_chan = '0;
        for (int k = NUM_CHAN; k >= 1; k--) begin
            idx = (int'(cur_chan) + k) % NUM_CHAN;
            if (pending[idx]) begin
                gnt_vld  = 1'b1;
                gnt_chan = CHAN_BITS'(idx);
            end
        end
    end

    assign credit  = {1'b0, fifo_cnt} + 4'(v1) + 4'(v2);
    assign issue   = busy && (credit < 4'd4);  // never overruns the fifo
    assign last_rd = (rd_cnt == '1);

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            pn_r     <= 1'b0;
            cur_chan <= CHAN_BITS'(NUM_CHAN - 1);  // first grant starts at 0
            rd_cnt   <= '0;
            pending  <= '0;
            v1       <= 1'b0;
            v2       <= 1'b0;
        end else begin
            pn_r <= issue && last_rd;
            pending <= (pending & ~(pn_r ? NUM_CHAN'(1) << cur_chan : '0)) | commit;
            if (!busy && !pn_r && gnt_vld) begin  // wait out page_next
                busy     <= 1'b1;
                cur_chan <= gnt_chan;
                rd_cnt   <= '0;
            end else if (issue) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (last_rd) begin
                    busy <= 1'b0;
                end
            end
            v1 <= issue;  // track reads through the 2-cycle buffer latency
            v2 <= v1;
        end
    end

    // read tags, payload only
    always_ff @(posedge rclk) begin
        c1 <= cur_chan;
        l1 <= last_rd;
        c2 <= c1;
        l2 <= l1;
    end

    genvar i;
    generate
        for (i = 0; i < NUM_CHAN; i++) begin : g_chan
            assign bus[i].rd        = issue && (cur_chan == CHAN_BITS'(i));
            assign bus[i].page_next = pn_r && (cur_chan == CHAN_BITS'(i));
            assign rdata[i]         = bus[i].data_out;
        end
    endgenerate

    assign push = v2;  // data_out valid now
    assign pop  = mem_valid && mem_ready;

    always_ff @(posedge rclk) begin
        if (push) begin
            fifo_data[wr_ptr] <= rdata[c2];
            fifo_chan[wr_ptr] <= c2;
            fifo_last[wr_ptr] <= l2;
        end
    end

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            fifo_cnt <= fifo_cnt + 3'(push) - 3'(pop);
        end
    end

    assign mem_valid = (fifo_cnt != 3'd0);
    assign mem_data  = fifo_data[rd_ptr];
    assign mem_chan  = fifo_chan[rd_ptr];
    assign mem_last  = fifo_last[rd_ptr];  // end of page burst

endmodule
